// ==== logic/rrvPkg.sv ====
package rrvPkg;

    localparam int unsigned XLEN = 32;
    localparam int unsigned REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] EBREAK_INSTR = 32'h0010_0073;

    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        I_OP   = 7'b0010011,
        R_OP   = 7'b0110011
    } tOpcode;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } tAluOp;

    // Values match funct3 of the branch encodings
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } tBranchType;

    typedef enum logic [1:0] {
        WB_ALU, WB_DMEM, WB_PC4
    } tSelWrBack;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        tOpcode     opcode;
    } tInstrR;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        tOpcode      opcode;
    } tInstrI;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        tOpcode     opcode;
    } tInstrS;

    typedef struct packed {
        logic       imm12;
        logic [5:0] immHi;          // imm[10:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;          // imm[4:1]
        logic       imm11;
        tOpcode     opcode;
    } tInstrB;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        tOpcode      opcode;
    } tInstrU;

    typedef struct packed {
        logic       imm20;
        logic [9:0] immLo;          // imm[10:1]
        logic       imm11;
        logic [7:0] immHi;          // imm[19:12]
        logic [4:0] rd;
        tOpcode     opcode;
    } tInstrJ;

    typedef union packed {
        tInstrR r;
        tInstrI i;
        tInstrS s;
        tInstrB b;
        tInstrU u;
        tInstrJ j;
    } tInstr;

endpackage

// ==== logic/rrvFetch.sv ====
`timescale 1ns/100ps

module rrvFetch (
    input  logic                     Clock,
    input  logic                     arstN,
    input  logic                     stall,
    input  logic                     halt,
    input  logic                     isJump,
    input  logic                     branchTaken,
    input  logic [rrvPkg::XLEN-1:0]  target,
    output logic [rrvPkg::XLEN-1:0]  imemAddr,
    output logic [rrvPkg::XLEN-1:0]  pcQ101,
    output logic                     halted
);

    logic [rrvPkg::XLEN-1:0] pc;      // Address being fetched
    logic                    freeze;
    logic                    redirect;

    assign imemAddr = pc;
    assign freeze   = stall | halt | halted;
    assign redirect = isJump | branchTaken;

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pc     <= rrvPkg::RESET_PC;
            pcQ101 <= rrvPkg::RESET_PC;
            halted <= 1'b0;
        end else begin
            if (halt) begin
                halted <= 1'b1;             // Sticky until reset
            end
            if (!freeze) begin
                pcQ101 <= pc;               // Tags the word arriving next cycle
                if (redirect) begin
                    pc <= {target[rrvPkg::XLEN-1:1], 1'b0};   // JALR clears bit 0
                end else begin
                    pc <= pc + 32'd4;
                end
            end
        end
    end

endmodule

// ==== logic/rrvCtrl.sv ====
`timescale 1ns/100ps

module rrvCtrl (
    input  logic                            Clock,
    input  logic                            arstN,
    input  logic [rrvPkg::XLEN-1:0]         imemData,
    input  logic                            stall,
    output logic [rrvPkg::REG_ADDR_W-1:0]   regSrc1,
    output logic [rrvPkg::REG_ADDR_W-1:0]   regSrc2,
    output logic [rrvPkg::REG_ADDR_W-1:0]   regDstQ102,
    output logic                            regWrEnQ102,
    output rrvPkg::tAluOp                   aluOp,
    output logic                            immInstr,
    output logic                            selAluPc,
    output logic                            lui,
    output rrvPkg::tBranchType              branchOp,
    output logic                            isBranch,
    output logic                            isJump,
    output logic                            dmemRdEn,
    output logic                            dmemWrEn,
    output logic [3:0]                      dmemByteEn,
    output logic                            signExt,
    output rrvPkg::tSelWrBack               selWrBackQ102,
    output logic [rrvPkg::XLEN-1:0]         immediate,
    output logic                            halt,
    input  logic                            branchTaken
);

    rrvPkg::tInstr           instrQ101;
    logic [rrvPkg::XLEN-1:0] holdWord;
    logic                    useHold;
    logic                    holdNext;
    logic                    squashQ102;    // Set after a control transfer
    logic                    regWrEn;
    rrvPkg::tSelWrBack       selWrBack;

    function automatic rrvPkg::tAluOp aluOpFor(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? rrvPkg::SUB : rrvPkg::ADD;
            3'b001:  return rrvPkg::SLL;
            3'b010:  return rrvPkg::SLT;
            3'b011:  return rrvPkg::SLTU;
            3'b100:  return rrvPkg::XOR;
            3'b101:  return alt ? rrvPkg::SRA : rrvPkg::SRL;
            3'b110:  return rrvPkg::OR;
            default: return rrvPkg::AND;
        endcase
    endfunction

    // A held word wins over a fresh fetch
    assign instrQ101 = useHold    ? holdWord :
                       squashQ102 ? rrvPkg::NOP_INSTR : imemData;

    assign regSrc1    = instrQ101.r.rs1;
    assign regSrc2    = instrQ101.r.rs2;
    assign branchOp   = rrvPkg::tBranchType'(instrQ101.r.funct3);
    assign signExt    = ~instrQ101.r.funct3[2];
    assign dmemByteEn = (instrQ101.r.funct3[1:0] == 2'b00) ? 4'b0001 :
                        (instrQ101.r.funct3[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
    assign halt       = (instrQ101 == rrvPkg::EBREAK_INSTR);
    assign holdNext   = stall | halt;

    always_comb begin
        aluOp     = rrvPkg::ADD;            // Address and target math
        immInstr  = 1'b1;
        selAluPc  = 1'b0;
        lui       = 1'b0;
        isBranch  = 1'b0;
        isJump    = 1'b0;
        dmemRdEn  = 1'b0;
        dmemWrEn  = 1'b0;
        regWrEn   = 1'b0;
        selWrBack = rrvPkg::WB_ALU;
        immediate = {{20{instrQ101.i.imm[11]}}, instrQ101.i.imm};
        case (instrQ101.r.opcode)
            rrvPkg::LUI: begin
                regWrEn   = 1'b1;
                lui       = 1'b1;
                immediate = {instrQ101.u.imm, 12'b0};
            end
            rrvPkg::AUIPC: begin
                regWrEn   = 1'b1;
                selAluPc  = 1'b1;
                immediate = {instrQ101.u.imm, 12'b0};
            end
            rrvPkg::JAL: begin
                regWrEn   = 1'b1;
                isJump    = 1'b1;
                selAluPc  = 1'b1;
                selWrBack = rrvPkg::WB_PC4;
                immediate = {{11{instrQ101.j.imm20}}, instrQ101.j.imm20, instrQ101.j.immHi,
                             instrQ101.j.imm11, instrQ101.j.immLo, 1'b0};
            end
            rrvPkg::JALR: begin
                regWrEn   = 1'b1;
                isJump    = 1'b1;
                selWrBack = rrvPkg::WB_PC4;
            end
            rrvPkg::BRANCH: begin
                isBranch  = 1'b1;
                selAluPc  = 1'b1;           // ALU forms PC plus offset
                immediate = {{19{instrQ101.b.imm12}}, instrQ101.b.imm12, instrQ101.b.imm11,
                             instrQ101.b.immHi, instrQ101.b.immLo, 1'b0};
            end
            rrvPkg::LOAD: begin
                regWrEn   = 1'b1;
                dmemRdEn  = 1'b1;
                selWrBack = rrvPkg::WB_DMEM;
            end
            rrvPkg::STORE: begin
                dmemWrEn  = 1'b1;
                immediate = {{20{instrQ101.s.immHi[6]}}, instrQ101.s.immHi, instrQ101.s.immLo};
            end
            rrvPkg::I_OP: begin
                regWrEn   = 1'b1;
                aluOp     = aluOpFor(instrQ101.i.funct3,
                                     (instrQ101.i.funct3 == 3'b101) & instrQ101.r.funct7[5]);
            end
            rrvPkg::R_OP: begin
                regWrEn   = 1'b1;
                immInstr  = 1'b0;
                aluOp     = aluOpFor(instrQ101.r.funct3, instrQ101.r.funct7[5]);
            end
            default: ;                      // Treated as NOP
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            squashQ102    <= 1'b1;          // Hide the word fetched during reset
            useHold       <= 1'b0;
            regWrEnQ102   <= 1'b0;
            regDstQ102    <= '0;
            selWrBackQ102 <= rrvPkg::WB_ALU;
        end else begin
            squashQ102    <= isJump | (isBranch & branchTaken);
            useHold       <= holdNext;
            regWrEnQ102   <= regWrEn & ~stall;   // Bubble while stalled
            regDstQ102    <= instrQ101.r.rd;
            selWrBackQ102 <= selWrBack;
        end
    end

    always_ff @(posedge Clock) begin
        if (holdNext) begin
            holdWord <= instrQ101;
        end
    end

endmodule

// ==== logic/rrvRegFile.sv ====
`timescale 1ns/100ps

module rrvRegFile (
    input  logic                            Clock,
    input  logic                            arstN,
    input  logic [rrvPkg::REG_ADDR_W-1:0]   regSrc1,
    input  logic [rrvPkg::REG_ADDR_W-1:0]   regSrc2,
    output logic [rrvPkg::XLEN-1:0]         rdData1,
    output logic [rrvPkg::XLEN-1:0]         rdData2,
    input  logic [rrvPkg::REG_ADDR_W-1:0]   regDstQ102,
    input  logic                            regWrEnQ102,
    input  logic [rrvPkg::XLEN-1:0]         wrData
);

    logic [rrvPkg::XLEN-1:0] regs [0:31];   // x0 kept at zero by the write gate

    assign rdData1 = regs[regSrc1];
    assign rdData2 = regs[regSrc2];

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrEnQ102 && (regDstQ102 != '0)) begin
            regs[regDstQ102] <= wrData;
        end
    end

    // A write aimed at x0 must not show up on a later read
    assert property (@(posedge Clock) disable iff (!arstN)
        (regSrc1 == '0) |-> (rdData1 == '0));
    assert property (@(posedge Clock) disable iff (!arstN)
        (regSrc2 == '0) |-> (rdData2 == '0));

endmodule

// ==== logic/rrvExec.sv ====
`timescale 1ns/100ps

module rrvExec (
    input  logic                            Clock,
    input  logic                            arstN,
    input  logic                            stall,
    input  logic [rrvPkg::XLEN-1:0]         rdData1,
    input  logic [rrvPkg::XLEN-1:0]         rdData2,
    input  logic [rrvPkg::XLEN-1:0]         immediate,
    input  logic [rrvPkg::XLEN-1:0]         pcQ101,
    input  rrvPkg::tAluOp                   aluOp,
    input  logic                            immInstr,
    input  logic                            selAluPc,
    input  logic                            lui,
    input  rrvPkg::tBranchType              branchOp,
    input  logic                            isBranch,
    input  logic [rrvPkg::REG_ADDR_W-1:0]   regSrc1,
    input  logic [rrvPkg::REG_ADDR_W-1:0]   regSrc2,
    input  logic [rrvPkg::REG_ADDR_W-1:0]   regDstQ102,
    input  logic                            regWrEnQ102,
    input  rrvPkg::tSelWrBack               selWrBackQ102,
    input  logic [rrvPkg::XLEN-1:0]         loadData,
    output logic [rrvPkg::XLEN-1:0]         aluOut,
    output logic                            branchTaken,
    output logic [rrvPkg::XLEN-1:0]         storeData,
    output logic [rrvPkg::XLEN-1:0]         wrData
);

    logic [rrvPkg::XLEN-1:0] rs1Val, rs2Val;
    logic [rrvPkg::XLEN-1:0] opA, opB;
    logic [rrvPkg::XLEN-1:0] aluOutQ102, pcPlus4Q102;
    logic                    fwd1, fwd2;
    logic                    cond;

    // Q102 result bypasses the register file
    assign fwd1   = regWrEnQ102 && (regDstQ102 != '0) && (regDstQ102 == regSrc1);
    assign fwd2   = regWrEnQ102 && (regDstQ102 != '0) && (regDstQ102 == regSrc2);
    assign rs1Val = fwd1 ? wrData : rdData1;
    assign rs2Val = fwd2 ? wrData : rdData2;

    assign opA       = lui ? '0 : (selAluPc ? pcQ101 : rs1Val);
    assign opB       = immInstr ? immediate : rs2Val;
    assign storeData = rs2Val;

    always_comb begin
        case (aluOp)
            rrvPkg::SUB:  aluOut = opA - opB;
            rrvPkg::SLL:  aluOut = opA << opB[4:0];
            rrvPkg::SLT:  aluOut = {31'b0, $signed(opA) < $signed(opB)};
            rrvPkg::SLTU: aluOut = {31'b0, opA < opB};
            rrvPkg::XOR:  aluOut = opA ^ opB;
            rrvPkg::SRL:  aluOut = opA >> opB[4:0];
            rrvPkg::SRA:  aluOut = $unsigned($signed(opA) >>> opB[4:0]);
            rrvPkg::OR:   aluOut = opA | opB;
            rrvPkg::AND:  aluOut = opA & opB;
            default:      aluOut = opA + opB;
        endcase
    end

    always_comb begin
        case (branchOp)
            rrvPkg::BEQ:  cond = (rs1Val == rs2Val);
            rrvPkg::BNE:  cond = (rs1Val != rs2Val);
            rrvPkg::BLT:  cond = ($signed(rs1Val) < $signed(rs2Val));
            rrvPkg::BGE:  cond = ($signed(rs1Val) >= $signed(rs2Val));
            rrvPkg::BLTU: cond = (rs1Val < rs2Val);
            rrvPkg::BGEU: cond = (rs1Val >= rs2Val);
            default:      cond = 1'b0;
        endcase
    end

    assign branchTaken = isBranch & cond;

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            aluOutQ102  <= '0;
            pcPlus4Q102 <= '0;
        end else if (!stall) begin
            aluOutQ102  <= aluOut;
            pcPlus4Q102 <= pcQ101 + 32'd4;  // Link value
        end
    end

    always_comb begin
        case (selWrBackQ102)
            rrvPkg::WB_DMEM: wrData = loadData;
            rrvPkg::WB_PC4:  wrData = pcPlus4Q102;
            default:         wrData = aluOutQ102;
        endcase
    end

endmodule

// ==== logic/rrvDataBus.sv ====
`timescale 1ns/100ps

module rrvDataBus (
    input  logic                     Clock,
    input  logic                     arstN,
    input  logic                     dmemRdEn,
    input  logic                     dmemWrEn,
    input  logic [3:0]               dmemByteEn,
    input  logic                     signExt,
    input  logic [rrvPkg::XLEN-1:0]  addr,
    input  logic [rrvPkg::XLEN-1:0]  storeData,
    output logic                     wbCyc,
    output logic                     wbStb,
    output logic                     wbWe,
    output logic [rrvPkg::XLEN-1:0]  wbAdr,
    output logic [rrvPkg::XLEN-1:0]  wbDatOut,
    output logic [3:0]               wbSel,
    input  logic [rrvPkg::XLEN-1:0]  wbDatIn,
    input  logic                     wbAck,
    output logic                     stall,
    output logic [rrvPkg::XLEN-1:0]  loadData
);

    logic                    memReq;
    logic                    ackGap;    // Idle cycle after each ack
    logic [rrvPkg::XLEN-1:0] laneWord;
    logic [rrvPkg::XLEN-1:0] extWord;

    assign memReq   = dmemRdEn | dmemWrEn;
    assign wbCyc    = memReq & ~ackGap;
    assign wbStb    = wbCyc;
    assign wbWe     = wbCyc & dmemWrEn;
    assign wbAdr    = {addr[rrvPkg::XLEN-1:2], 2'b00};
    assign wbSel    = dmemByteEn << addr[1:0];
    assign wbDatOut = (dmemByteEn == 4'b0001) ? {4{storeData[7:0]}} :
                      (dmemByteEn == 4'b0011) ? {2{storeData[15:0]}} : storeData;
    assign stall    = memReq & ~(wbCyc & wbAck);

    assign laneWord = wbDatIn >> {addr[1:0], 3'b000};

    always_comb begin
        case (dmemByteEn)
            4'b0001: extWord = {{24{signExt & laneWord[7]}}, laneWord[7:0]};
            4'b0011: extWord = {{16{signExt & laneWord[15]}}, laneWord[15:0]};
            default: extWord = laneWord;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            ackGap <= 1'b0;
        end else begin
            ackGap <= wbCyc & wbAck;
        end
    end

    always_ff @(posedge Clock) begin
        if (wbCyc && wbAck && !wbWe) begin
            loadData <= extWord;
        end
    end

    // No second access from the same request
    assert property (@(posedge Clock) disable iff (!arstN)
        (wbStb && wbAck) |=> !wbStb);

    // Held pipeline keeps the request steady through wait states
    assert property (@(posedge Clock) disable iff (!arstN)
        (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbWe)
                               && $stable(wbSel) && $stable(wbDatOut)));

endmodule

// ==== logic/rrvCore.sv ====
`timescale 1ns/100ps

module rrvCore (
    input  logic                     Clock,
    input  logic                     arstN,
    output logic [rrvPkg::XLEN-1:0]  imemAddr,
    input  logic [rrvPkg::XLEN-1:0]  imemData,
    output logic                     wbCyc,
    output logic                     wbStb,
    output logic                     wbWe,
    output logic [rrvPkg::XLEN-1:0]  wbAdr,
    output logic [rrvPkg::XLEN-1:0]  wbDatOut,
    output logic [3:0]               wbSel,
    input  logic [rrvPkg::XLEN-1:0]  wbDatIn,
    input  logic                     wbAck,
    output logic                     halted
);

    logic [rrvPkg::REG_ADDR_W-1:0] regSrc1, regSrc2, regDstQ102;
    logic                          regWrEnQ102;
    rrvPkg::tAluOp                 aluOp;
    rrvPkg::tBranchType            branchOp;
    rrvPkg::tSelWrBack             selWrBackQ102;
    logic                          immInstr, selAluPc, lui, isBranch, isJump;
    logic                          dmemRdEn, dmemWrEn, signExt;
    logic [3:0]                    dmemByteEn;
    logic                          halt, stall, branchTaken;
    logic [rrvPkg::XLEN-1:0]       immediate, pcQ101, rdData1, rdData2;
    logic [rrvPkg::XLEN-1:0]       aluOut, storeData, wrData, loadData;

    rrvFetch u_fetch (
        .Clock, .arstN, .stall, .halt, .isJump, .branchTaken,
        .target (aluOut), .imemAddr, .pcQ101, .halted
    );

    rrvCtrl u_ctrl (
        .Clock, .arstN, .imemData, .stall,
        .regSrc1, .regSrc2, .regDstQ102, .regWrEnQ102,
        .aluOp, .immInstr, .selAluPc, .lui, .branchOp, .isBranch, .isJump,
        .dmemRdEn, .dmemWrEn, .dmemByteEn, .signExt,
        .selWrBackQ102, .immediate, .halt, .branchTaken
    );

    rrvRegFile u_regFile (
        .Clock, .arstN, .regSrc1, .regSrc2, .rdData1, .rdData2,
        .regDstQ102, .regWrEnQ102, .wrData
    );

    rrvExec u_exec (
        .Clock, .arstN, .stall, .rdData1, .rdData2, .immediate, .pcQ101,
        .aluOp, .immInstr, .selAluPc, .lui, .branchOp, .isBranch,
        .regSrc1, .regSrc2, .regDstQ102, .regWrEnQ102, .selWrBackQ102, .loadData,
        .aluOut, .branchTaken, .storeData, .wrData
    );

    rrvDataBus u_dataBus (
        .Clock, .arstN, .dmemRdEn, .dmemWrEn, .dmemByteEn, .signExt,
        .addr (aluOut), .storeData,
        .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatOut, .wbSel, .wbDatIn, .wbAck,
        .stall, .loadData
    );

endmodule

// ==== verif/tbRrvCore.sv ====
`timescale 1ns/100ps

module tbRrvCore;

    localparam int PERIOD      = 8;
    localparam int PROG_WORDS  = 80;        // Program region @00..@4f
    localparam int LOAD_BASE   = 'h50;
    localparam int STORE_BASE  = 'h60;
    localparam int PAT_DEPTH   = 'h90;
    localparam int MAX_STORES  = 16;
    localparam int WORST_CPI   = 8;         // Gap, request, three waits, ack, margin
    localparam int TIMEOUT_NS  = (4 + PROG_WORDS * WORST_CPI * 2 + 50) * PERIOD;

    logic                     Clock;
    logic                     arstN;
    logic [rrvPkg::XLEN-1:0]  imemAddr;
    logic [rrvPkg::XLEN-1:0]  imemData;
    logic                     wbCyc, wbStb, wbWe;
    logic [rrvPkg::XLEN-1:0]  wbAdr, wbDatOut, wbDatIn;
    logic [3:0]               wbSel;
    logic                     wbAck;
    logic                     halted;

    logic [31:0] pat [0:PAT_DEPTH-1];
    logic [31:0] romIdx;
    logic [31:0] haltPc;
    integer      seed = 32'he54d953a;
    int          storeCount;
    int          storeIdx;
    int          loadCount;
    int          loadExpected;
    int          waitLeft;
    logic        busy;

    rrvCore u_dut (
        .Clock, .arstN, .imemAddr, .imemData,
        .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatOut, .wbSel, .wbDatIn, .wbAck,
        .halted
    );

    always #(PERIOD / 2) Clock = ~Clock;

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    // Called at the edge that consumes ack, before the core reacts
    task automatic recordAccess();
        int base;
        if (wbWe) begin
            if (storeIdx >= storeCount) begin
                checkEq(wbAdr, 32'hffff_ffff, "unexpected extra store at address");
            end
            base = STORE_BASE + 3 * storeIdx;
            checkEq(wbAdr, pat[base], $sformatf("store %0d address", storeIdx));
            checkEq({28'b0, wbSel}, pat[base + 1], $sformatf("store %0d sel", storeIdx));
            checkEq(wbDatOut, pat[base + 2], $sformatf("store %0d data", storeIdx));
            storeIdx++;
        end else begin
            loadCount++;
        end
    endtask

    // Instruction ROM with one cycle of read latency
    always @(posedge Clock) begin
        romIdx = imemAddr >> 2;
        #1;
        imemData = (romIdx < PROG_WORDS) ? pat[romIdx] : rrvPkg::NOP_INSTR;
    end

    // Wishbone slave with random wait states
    always @(posedge Clock) begin
        if (arstN) begin
            if (wbAck) begin
                recordAccess();
                #1;
                wbAck = 1'b0;
                busy  = 1'b0;
            end else if (wbStb) begin
                if (!busy) begin
                    busy     = 1'b1;
                    waitLeft = $unsigned($random(seed)) % 4;
                end else begin
                    waitLeft--;
                end
                if (waitLeft == 0) begin
                    #1;
                    wbDatIn = pat[LOAD_BASE + wbAdr[5:2]];
                    wbAck   = 1'b1;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the core did not halt within %0d ns", TIMEOUT_NS);
        $display("Some tests failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        Clock     = 1'b0;
        arstN     = 1'b0;
        imemData  = rrvPkg::NOP_INSTR;
        wbDatIn   = '0;
        wbAck     = 1'b0;
        busy      = 1'b0;
        waitLeft  = 0;
        storeIdx  = 0;
        loadCount = 0;
        $readmemh("verif/rrvPatterns.mem", pat);

        storeCount = 0;
        while (storeCount < MAX_STORES && pat[STORE_BASE + 3 * storeCount] !== 32'hffff_ffff) begin
            storeCount++;
        end
        loadExpected = pat[STORE_BASE + 3 * storeCount + 1];

        repeat (4) @(posedge Clock);
        #2;
        checkEq({31'b0, wbCyc}, 0, "wbCyc in reset");
        checkEq({31'b0, wbStb}, 0, "wbStb in reset");
        checkEq({31'b0, wbWe}, 0, "wbWe in reset");
        checkEq({31'b0, halted}, 0, "halted in reset");
        checkEq(imemAddr, rrvPkg::RESET_PC, "imemAddr in reset");
        arstN = 1'b1;

        wait (halted === 1'b1);
        @(posedge Clock);
        #2;
        haltPc = imemAddr;
        repeat (10) begin
            @(posedge Clock);
            #2;
            checkEq({31'b0, wbCyc}, 0, "bus cycle after halt");
            checkEq(imemAddr, haltPc, "PC after halt");
            checkEq({31'b0, halted}, 1, "halted held");
        end
        checkEq(storeIdx, storeCount, "number of stores seen");
        checkEq(loadCount, loadExpected, "number of loads seen");
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== verif/rrvPatterns.mem ====
// @00 program words; @50 load response words indexed by address bits 5:2
// @60 expected stores as address sel data, closed by ffffffff <load count> 0
@00
20000113 ffb00093 00300193 40308233 // x2 base, x1=-5, x3=3, sub
00412023 403252b3 00512223 0030a333 // sw, sra, sw, slt
0011b3b3 00431413 00740433 00812423 // sltu, slli, add chain, sw
001106a3 00411923 10000493 00148503 // sb, sh, load base, lb
00a12a23 0034c583 00249603 0004d683 // sw, lbu, lh, lhu
0044a703 00b12c23 00c12e23 02d12023 // lw, stores of loaded values
02e12223
00179793 00730463 00178793 // beq taken
00179793 00308463 00178793 // beq not taken
00179793 00309463 00178793 // bne taken
00179793 00731463 00178793 // bne not taken
00179793 0030c463 00178793 // blt taken
00179793 0011c463 00178793 // blt not taken
00179793 0011d463 00178793 // bge taken
00179793 0030d463 00178793 // bge not taken
00179793 0011e463 00178793 // bltu taken
00179793 0030e463 00178793 // bltu not taken
00179793 0030f463 00178793 // bgeu taken
00179793 0011f463 00178793 // bgeu not taken
02f12423 00c0086f 02012623 02012623 // sw flags, jal over markers
03012623 00001897 01c80967 02012623 // sw link, auipc, jalr, marker
02012623 abcde9b7 03112823 03212a23 // marker, lui, stores
03312c23 00100073 00000013          // store, ebreak, pad
@50
8091a2b3 7f6e5d4c
@60
00000200 f fffffff8
00000204 f ffffffff
00000208 f 00000011
0000020c 2 fbfbfbfb
00000210 c fff8fff8
00000214 f ffffffa2
00000218 f 00000080
0000021c f ffff8091
00000220 f 0000a2b3
00000224 f 7f6e5d4c
00000228 f 00000555
0000022c f 000000fc
00000230 f 00001108
00000234 f 00000110
00000238 f abcde000
ffffffff 5 00000000

// ==== flist.f ====
logic/rrvPkg.sv
logic/rrvFetch.sv
logic/rrvCtrl.sv
logic/rrvRegFile.sv
logic/rrvExec.sv
logic/rrvDataBus.sv
logic/rrvCore.sv
verif/tbRrvCore.sv
